//--- compile.f
cpu_pkg.sv
reg_file.sv
decoder.sv
id_ex.sv
ex_stage.sv
ex_wb.sv
exec_core.sv
tb_clock.sv
tb_exec_core.sv

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int REG_COUNT  = 32;
	localparam int SHAMT_W    = 5;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [2:0]            mem_width_t; // funct3 of loads and stores

	localparam word_t      ZERO_WORD = '0;
	localparam word_t      NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0
	localparam mem_width_t MEM_WORD  = 3'b010;

	// instruction field positions
	localparam int RD_LSB     = 7;
	localparam int FUNCT3_LSB = 12;
	localparam int RS1_LSB    = 15;
	localparam int RS2_LSB    = 20;
	localparam int ALT_BIT    = 30; // funct7[5], sub / sra

	//////////////////////////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [6:0] {
		OP_REG   = 7'b0110011,
		OP_IMM   = 7'b0010011,
		OP_LUI   = 7'b0110111,
		OP_LOAD  = 7'b0000011,
		OP_STORE = 7'b0100011
	} opcode_e;

	// values follow funct3 so OP and OP-IMM map straight through
	typedef enum logic [2:0] {
		ALU_ADD  = 3'b000, // sub with funct
		ALU_SLL  = 3'b001,
		ALU_SLT  = 3'b010,
		ALU_SLTU = 3'b011,
		ALU_XOR  = 3'b100,
		ALU_SRL  = 3'b101, // sra with funct
		ALU_OR   = 3'b110,
		ALU_AND  = 3'b111
	} alu_sel_e;

endpackage

`default_nettype wire

//--- decoder.sv
`default_nettype none

module decoder (
	input  cpu_pkg::word_t      instr,
	input  logic                instr_valid,
	input  cpu_pkg::word_t      rdata1,
	input  cpu_pkg::word_t      rdata2,
	input  logic                ex_we,     // pending write in id/ex
	input  cpu_pkg::reg_addr_t  ex_waddr,
	output cpu_pkg::reg_addr_t  raddr1,
	output cpu_pkg::reg_addr_t  raddr2,
	output cpu_pkg::alu_sel_e   alu_sel,
	output logic                funct,
	output cpu_pkg::word_t      data1,
	output cpu_pkg::word_t      data2,
	output cpu_pkg::word_t      store_data,
	output logic                we,
	output cpu_pkg::reg_addr_t  waddr,
	output logic                ma_we,
	output logic                ma_re,
	output cpu_pkg::mem_width_t ma_width,
	output logic                stall_id
);

	cpu_pkg::word_t     inst;
	cpu_pkg::opcode_e   opcode;
	logic [2:0]         funct3;
	cpu_pkg::reg_addr_t rd;
	cpu_pkg::word_t     imm_i;
	cpu_pkg::word_t     imm_s;
	cpu_pkg::word_t     imm_u;
	logic               use1;
	logic               use2;

	// an empty slot decodes exactly like the canonical nop
	assign inst = instr_valid ? instr : cpu_pkg::NOP_INSTR;

	assign opcode = cpu_pkg::opcode_e'(inst[6:0]);
	assign funct3 = inst[cpu_pkg::FUNCT3_LSB +: 3];
	assign rd     = inst[cpu_pkg::RD_LSB +: cpu_pkg::REG_ADDR_W];
	assign raddr1 = inst[cpu_pkg::RS1_LSB +: cpu_pkg::REG_ADDR_W];
	assign raddr2 = inst[cpu_pkg::RS2_LSB +: cpu_pkg::REG_ADDR_W];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_u = {inst[31:12], 12'b0};

	//////////////////////////////////////////////////////////////////////
	// field decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		alu_sel    = cpu_pkg::ALU_ADD;
		funct      = 1'b0;
		data1      = cpu_pkg::ZERO_WORD;
		data2      = cpu_pkg::ZERO_WORD;
		store_data = cpu_pkg::ZERO_WORD;
		we         = 1'b0;
		waddr      = '0;
		ma_we      = 1'b0;
		ma_re      = 1'b0;
		ma_width   = cpu_pkg::MEM_WORD; // only word access exists
		use1       = 1'b0;
		use2       = 1'b0;

		case (opcode)
			cpu_pkg::OP_REG: begin
				alu_sel = cpu_pkg::alu_sel_e'(funct3);
				funct   = inst[cpu_pkg::ALT_BIT];
				data1   = rdata1;
				data2   = rdata2;
				use1    = 1'b1;
				use2    = 1'b1;
				we      = (rd != '0);
				waddr   = rd;
			end
			cpu_pkg::OP_IMM: begin
				alu_sel = cpu_pkg::alu_sel_e'(funct3);
				// addi has no subtract form, only srai uses the alt bit
				funct   = (funct3 == 3'b101) && inst[cpu_pkg::ALT_BIT];
				data1   = rdata1;
				data2   = imm_i;
				use1    = 1'b1;
				we      = (rd != '0);
				waddr   = rd;
			end
			cpu_pkg::OP_LUI: begin
				data2 = imm_u; // x0 + imm
				we    = (rd != '0);
				waddr = rd;
			end
			cpu_pkg::OP_LOAD: begin
				if (funct3 == cpu_pkg::MEM_WORD) begin
					data1 = rdata1;
					data2 = imm_i;
					use1  = 1'b1;
					ma_re = 1'b1;
					we    = (rd != '0);
					waddr = rd;
				end
			end
			cpu_pkg::OP_STORE: begin
				if (funct3 == cpu_pkg::MEM_WORD) begin
					data1      = rdata1;
					data2      = imm_s;
					store_data = rdata2;
					use1       = 1'b1;
					use2       = 1'b1;
					ma_we      = 1'b1;
				end
			end
			default: ; // unsupported, stays a nop
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// hazard check
	//////////////////////////////////////////////////////////////////////

	// write-back results reach decode by write-through, so only execute counts
	assign stall_id = ex_we && (
		(use1 && raddr1 != '0 && raddr1 == ex_waddr) ||
		(use2 && raddr2 != '0 && raddr2 == ex_waddr));

endmodule

`default_nettype wire

//--- ex_stage.sv
`default_nettype none

module ex_stage (
	input  cpu_pkg::alu_sel_e   alu_sel,
	input  logic                funct,
	input  cpu_pkg::word_t      data1,
	input  cpu_pkg::word_t      data2,
	input  cpu_pkg::word_t      store_data,
	input  logic                we_in,
	input  cpu_pkg::reg_addr_t  waddr_in,
	input  logic                ma_we_in,
	input  logic                ma_re_in,
	input  cpu_pkg::mem_width_t ma_width_in,
	output logic                we,
	output cpu_pkg::reg_addr_t  waddr,
	output cpu_pkg::word_t      alu_out,
	output logic                ma_we,
	output logic                ma_re,
	output cpu_pkg::mem_width_t ma_width,
	output cpu_pkg::word_t      ma_addr,
	output cpu_pkg::word_t      ma_wdata
);

	logic [cpu_pkg::SHAMT_W-1:0] shamt;

	assign shamt = data2[cpu_pkg::SHAMT_W-1:0];

	//////////////////////////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (alu_sel)
			cpu_pkg::ALU_AND: alu_out = data1 & data2;
			cpu_pkg::ALU_OR:  alu_out = data1 | data2;
			cpu_pkg::ALU_XOR: alu_out = data1 ^ data2;
			cpu_pkg::ALU_ADD: begin
				if (funct) alu_out = data1 - data2;
				else alu_out = data1 + data2;
			end
			cpu_pkg::ALU_SLT: begin
				alu_out = {31'b0, $signed(data1) < $signed(data2)};
			end
			cpu_pkg::ALU_SLTU: alu_out = {31'b0, data1 < data2};
			cpu_pkg::ALU_SLL:  alu_out = data1 << shamt;
			cpu_pkg::ALU_SRL: begin
				if (funct) alu_out = cpu_pkg::word_t'($signed(data1) >>> shamt);
				else alu_out = data1 >> shamt;
			end
			default: alu_out = cpu_pkg::ZERO_WORD;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// pass-through and memory request
	//////////////////////////////////////////////////////////////////////

	assign we       = we_in;
	assign waddr    = waddr_in;
	assign ma_we    = ma_we_in;
	assign ma_re    = ma_re_in;
	assign ma_width = ma_width_in;

	// address and data only for memory ops
	assign ma_addr  = (ma_we_in | ma_re_in) ? alu_out : cpu_pkg::ZERO_WORD;
	assign ma_wdata = ma_we_in ? store_data : cpu_pkg::ZERO_WORD;

endmodule

`default_nettype wire

//--- ex_wb.sv
`default_nettype none

module ex_wb (
	input  logic                clk,
	input  logic                reset,
	input  logic                rdy,
	input  logic                we,
	input  cpu_pkg::reg_addr_t  waddr,
	input  cpu_pkg::word_t      alu_out,
	input  logic                ex_ma_we,
	input  logic                ex_ma_re,
	input  cpu_pkg::mem_width_t ex_ma_width,
	input  cpu_pkg::word_t      ex_ma_addr,
	input  cpu_pkg::word_t      ex_ma_wdata,
	input  cpu_pkg::word_t      mem_rdata,
	output logic                ma_we,
	output logic                ma_re,
	output cpu_pkg::mem_width_t ma_width,
	output cpu_pkg::word_t      ma_addr,
	output cpu_pkg::word_t      ma_wdata,
	output logic                wb_we,
	output cpu_pkg::reg_addr_t  wb_waddr,
	output cpu_pkg::word_t      wb_wdata
);

	logic           we_r;
	logic           ma_we_r;
	logic           ma_re_r;
	cpu_pkg::word_t alu_r;

	always_ff @(posedge clk) begin
		if (reset) begin
			we_r    <= 1'b0;
			ma_we_r <= 1'b0;
			ma_re_r <= 1'b0;
		end else if (rdy) begin
			we_r    <= we;
			ma_we_r <= ex_ma_we;
			ma_re_r <= ex_ma_re;
		end
	end

	always_ff @(posedge clk) begin
		if (rdy) begin
			wb_waddr <= waddr;
			alu_r    <= alu_out;
			ma_width <= ex_ma_width;
			ma_addr  <= ex_ma_addr;
			ma_wdata <= ex_ma_wdata;
		end
	end

	assign ma_we    = ma_we_r & rdy; // no request while frozen
	assign ma_re    = ma_re_r & rdy;
	assign wb_we    = we_r & rdy;
	assign wb_wdata = ma_re_r ? mem_rdata : alu_r; // load data arrives this cycle

endmodule

`default_nettype wire

//--- exec_core.sv
`default_nettype none

module exec_core (
	input  logic                clk,
	input  logic                reset,
	input  logic                rdy,
	input  cpu_pkg::word_t      instr,
	input  logic                instr_valid,
	input  cpu_pkg::word_t      mem_rdata,
	output logic                instr_ready,
	output logic                ma_we,
	output logic                ma_re,
	output cpu_pkg::mem_width_t ma_width,
	output cpu_pkg::word_t      ma_addr,
	output cpu_pkg::word_t      ma_wdata,
	output logic                wb_we,
	output cpu_pkg::reg_addr_t  wb_waddr,
	output cpu_pkg::word_t      wb_wdata
);

	//////////////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////////////

	cpu_pkg::reg_addr_t  raddr1, raddr2;
	cpu_pkg::word_t      rdata1, rdata2;
	logic                stall_id;
	cpu_pkg::alu_sel_e   id_alu_sel;
	logic                id_funct;
	cpu_pkg::word_t      id_data1, id_data2, id_store_data;
	logic                id_we, id_ma_we, id_ma_re;
	cpu_pkg::reg_addr_t  id_waddr;
	cpu_pkg::mem_width_t id_ma_width;

	// id/ex outputs
	cpu_pkg::alu_sel_e   ex_alu_sel;
	logic                ex_funct;
	cpu_pkg::word_t      ex_data1, ex_data2, ex_store_data;
	logic                ex_we, ex_ma_we, ex_ma_re;
	cpu_pkg::reg_addr_t  ex_waddr;
	cpu_pkg::mem_width_t ex_ma_width;

	// execute results
	logic                x_we, x_ma_we, x_ma_re;
	cpu_pkg::reg_addr_t  x_waddr;
	cpu_pkg::word_t      x_alu_out, x_ma_addr, x_ma_wdata;
	cpu_pkg::mem_width_t x_ma_width;

	assign instr_ready = rdy & ~stall_id;

	reg_file reg_file_i (
		.clk(clk), .reset(reset), .raddr1(raddr1), .raddr2(raddr2),
		.we(wb_we), .waddr(wb_waddr), .wdata(wb_wdata),
		.rdata1(rdata1), .rdata2(rdata2)
	);

	decoder decoder_i (
		.instr(instr), .instr_valid(instr_valid), .rdata1(rdata1), .rdata2(rdata2),
		.ex_we(ex_we), .ex_waddr(ex_waddr), .raddr1(raddr1), .raddr2(raddr2),
		.alu_sel(id_alu_sel), .funct(id_funct), .data1(id_data1), .data2(id_data2),
		.store_data(id_store_data), .we(id_we), .waddr(id_waddr),
		.ma_we(id_ma_we), .ma_re(id_ma_re), .ma_width(id_ma_width), .stall_id(stall_id)
	);

	//////////////////////////////////////////////////////////////////////
	// execute and write-back
	//////////////////////////////////////////////////////////////////////

	id_ex id_ex_i (
		.clk(clk), .reset(reset), .rdy(rdy), .stall_id(stall_id),
		.id_alu_sel(id_alu_sel), .id_funct(id_funct), .id_data1(id_data1),
		.id_data2(id_data2), .id_store_data(id_store_data), .id_we(id_we),
		.id_waddr(id_waddr), .id_ma_we(id_ma_we), .id_ma_re(id_ma_re),
		.id_ma_width(id_ma_width), .ex_alu_sel(ex_alu_sel), .ex_funct(ex_funct),
		.ex_data1(ex_data1), .ex_data2(ex_data2), .ex_store_data(ex_store_data),
		.ex_we(ex_we), .ex_waddr(ex_waddr), .ex_ma_we(ex_ma_we), .ex_ma_re(ex_ma_re),
		.ex_ma_width(ex_ma_width)
	);

	ex_stage ex_stage_i (
		.alu_sel(ex_alu_sel), .funct(ex_funct), .data1(ex_data1), .data2(ex_data2),
		.store_data(ex_store_data), .we_in(ex_we), .waddr_in(ex_waddr),
		.ma_we_in(ex_ma_we), .ma_re_in(ex_ma_re), .ma_width_in(ex_ma_width),
		.we(x_we), .waddr(x_waddr), .alu_out(x_alu_out), .ma_we(x_ma_we),
		.ma_re(x_ma_re), .ma_width(x_ma_width), .ma_addr(x_ma_addr), .ma_wdata(x_ma_wdata)
	);

	ex_wb ex_wb_i (
		.clk(clk), .reset(reset), .rdy(rdy), .we(x_we), .waddr(x_waddr),
		.alu_out(x_alu_out), .ex_ma_we(x_ma_we), .ex_ma_re(x_ma_re),
		.ex_ma_width(x_ma_width), .ex_ma_addr(x_ma_addr), .ex_ma_wdata(x_ma_wdata),
		.mem_rdata(mem_rdata), .ma_we(ma_we), .ma_re(ma_re), .ma_width(ma_width),
		.ma_addr(ma_addr), .ma_wdata(ma_wdata), .wb_we(wb_we), .wb_waddr(wb_waddr),
		.wb_wdata(wb_wdata)
	);

endmodule

`default_nettype wire

//--- id_ex.sv
`default_nettype none

module id_ex (
	input  logic                clk,
	input  logic                reset,
	input  logic                rdy,
	input  logic                stall_id,
	input  cpu_pkg::alu_sel_e   id_alu_sel,
	input  logic                id_funct,
	input  cpu_pkg::word_t      id_data1,
	input  cpu_pkg::word_t      id_data2,
	input  cpu_pkg::word_t      id_store_data,
	input  logic                id_we,
	input  cpu_pkg::reg_addr_t  id_waddr,
	input  logic                id_ma_we,
	input  logic                id_ma_re,
	input  cpu_pkg::mem_width_t id_ma_width,
	output cpu_pkg::alu_sel_e   ex_alu_sel,
	output logic                ex_funct,
	output cpu_pkg::word_t      ex_data1,
	output cpu_pkg::word_t      ex_data2,
	output cpu_pkg::word_t      ex_store_data,
	output logic                ex_we,
	output cpu_pkg::reg_addr_t  ex_waddr,
	output logic                ex_ma_we,
	output logic                ex_ma_re,
	output cpu_pkg::mem_width_t ex_ma_width
);

	// strobes, cleared on reset and on a bubble
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_we    <= 1'b0;
			ex_ma_we <= 1'b0;
			ex_ma_re <= 1'b0;
		end else if (rdy) begin
			ex_we    <= id_we & ~stall_id;
			ex_ma_we <= id_ma_we & ~stall_id;
			ex_ma_re <= id_ma_re & ~stall_id;
		end
	end

	always_ff @(posedge clk) begin
		if (rdy) begin
			if (stall_id) begin // bubble is the decoded nop
				ex_alu_sel    <= cpu_pkg::ALU_ADD;
				ex_funct      <= 1'b0;
				ex_data1      <= cpu_pkg::ZERO_WORD;
				ex_data2      <= cpu_pkg::ZERO_WORD;
				ex_store_data <= cpu_pkg::ZERO_WORD;
				ex_waddr      <= '0;
				ex_ma_width   <= cpu_pkg::MEM_WORD;
			end else begin
				ex_alu_sel    <= id_alu_sel;
				ex_funct      <= id_funct;
				ex_data1      <= id_data1;
				ex_data2      <= id_data2;
				ex_store_data <= id_store_data;
				ex_waddr      <= id_waddr;
				ex_ma_width   <= id_ma_width;
			end
		end
	end

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::reg_addr_t raddr1,
	input  cpu_pkg::reg_addr_t raddr2,
	input  logic              we,
	input  cpu_pkg::reg_addr_t waddr,
	input  cpu_pkg::word_t     wdata,
	output cpu_pkg::word_t     rdata1,
	output cpu_pkg::word_t     rdata2
);

	cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
				regs[i] <= cpu_pkg::ZERO_WORD;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 reads zero, same-cycle write goes straight through
	always_comb begin
		if (raddr1 == '0) rdata1 = cpu_pkg::ZERO_WORD;
		else if (we && waddr == raddr1) rdata1 = wdata;
		else rdata1 = regs[raddr1];

		if (raddr2 == '0) rdata2 = cpu_pkg::ZERO_WORD;
		else if (we && waddr == raddr2) rdata2 = wdata;
		else rdata2 = regs[raddr2];
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the exec_core regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_exec_core -Mdir obj_dir -f compile.f
./obj_dir/Vtb_exec_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0

//--- tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD = 20;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// high for the first two rising edges
	initial begin
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tb_exec_core.sv
`default_nettype none

module tb_exec_core;

	localparam int N_INSTR     = 300;
	localparam int CYCLE_LIMIT = 4 * N_INSTR + 50;

	logic                clk;
	logic                reset;
	logic                rdy;
	cpu_pkg::word_t      instr;
	logic                instr_valid;
	cpu_pkg::word_t      mem_rdata;
	logic                instr_ready;
	logic                ma_we;
	logic                ma_re;
	cpu_pkg::mem_width_t ma_width;
	cpu_pkg::word_t      ma_addr;
	cpu_pkg::word_t      ma_wdata;
	logic                wb_we;
	cpu_pkg::reg_addr_t  wb_waddr;
	cpu_pkg::word_t      wb_wdata;

	// program, one entry per instruction
	cpu_pkg::word_t     prog_instr [N_INSTR];
	cpu_pkg::opcode_e   prog_op    [N_INSTR];
	logic [2:0]         prog_f3    [N_INSTR];
	logic               prog_alt   [N_INSTR];
	cpu_pkg::reg_addr_t prog_rd    [N_INSTR];
	cpu_pkg::reg_addr_t prog_rs1   [N_INSTR];
	cpu_pkg::reg_addr_t prog_rs2   [N_INSTR];
	cpu_pkg::word_t     prog_imm   [N_INSTR];

	cpu_pkg::word_t mem      [64]; // answers the DUT
	cpu_pkg::word_t ref_mem  [64]; // program-order copy
	logic           stored   [64];
	cpu_pkg::word_t ref_regs [cpu_pkg::REG_COUNT];

	// expected results in retire order
	logic               exp_store [$];
	cpu_pkg::reg_addr_t exp_rd    [$];
	cpu_pkg::word_t     exp_addr  [$];
	cpu_pkg::word_t     exp_data  [$];

	int                 cycles = 0;
	int                 stall_cycles;
	int                 load_hits;
	int                 idx;
	cpu_pkg::reg_addr_t ex_rd; // destination waiting in id/ex

	tb_clock tb_clock_i (.clk(clk), .reset(reset));

	exec_core exec_core_i (
		.clk(clk), .reset(reset), .rdy(rdy), .instr(instr), .instr_valid(instr_valid),
		.mem_rdata(mem_rdata), .instr_ready(instr_ready), .ma_we(ma_we), .ma_re(ma_re),
		.ma_width(ma_width), .ma_addr(ma_addr), .ma_wdata(ma_wdata), .wb_we(wb_we),
		.wb_waddr(wb_waddr), .wb_wdata(wb_wdata)
	);

	assign mem_rdata = mem[ma_addr[7:2]];

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t got,
			input cpu_pkg::word_t exp);
		if (got !== exp)
			report_failure($sformatf("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	task automatic check_reg_addr(input string name, input cpu_pkg::reg_addr_t got,
			input cpu_pkg::reg_addr_t exp);
		if (got !== exp)
			report_failure($sformatf("ERROR %s: got 0x%02h, expected 0x%02h", name, got, exp));
	endtask

	task automatic check_mem_width(input string name, input cpu_pkg::mem_width_t got,
			input cpu_pkg::mem_width_t exp);
		if (got !== exp)
			report_failure($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	function automatic cpu_pkg::word_t fill_word(input int i);
		return (cpu_pkg::word_t'(i) * 32'h9E37_79B9) ^ 32'h0F0F_5A5A;
	endfunction

	function automatic cpu_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
			input cpu_pkg::word_t a, input cpu_pkg::word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? cpu_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// decode holds while a used source waits in execute
	function automatic logic causes_stall(input int i, input cpu_pkg::reg_addr_t pend);
		logic use1;
		logic use2;
		use1 = (prog_op[i] != cpu_pkg::OP_LUI);
		use2 = (prog_op[i] == cpu_pkg::OP_REG) || (prog_op[i] == cpu_pkg::OP_STORE);
		return pend != '0 && ((use1 && prog_rs1[i] == pend) || (use2 && prog_rs2[i] == pend));
	endfunction

	//////////////////////////////////////////////////////////////////////
	// program and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic make_program();
		cpu_pkg::reg_addr_t prev_rd;
		int unsigned        pick;
		int                 off;
		logic [11:0]        imm12;
		// x1 is the load/store base and is never written again
		prog_op[0]    = cpu_pkg::OP_IMM;
		prog_f3[0]    = 3'd0;
		prog_alt[0]   = 1'b0;
		prog_rd[0]    = 5'd1;
		prog_rs1[0]   = '0;
		prog_rs2[0]   = '0;
		prog_imm[0]   = 32'd128;
		prog_instr[0] = {12'd128, 5'd0, 3'd0, 5'd1, cpu_pkg::OP_IMM};
		prev_rd = 5'd1;
		for (int i = 1; i < N_INSTR; i++) begin
			pick          = $urandom_range(0, 99);
			imm12         = 12'($urandom);
			prog_f3[i]    = 3'($urandom_range(0, 7));
			prog_alt[i]   = 1'($urandom_range(0, 1));
			prog_rd[i]    = cpu_pkg::reg_addr_t'($urandom_range(2, 31));
			if ($urandom_range(0, 15) == 0) prog_rd[i] = '0;
			prog_rs1[i] = ($urandom_range(0, 1) == 1) ? prev_rd
				: cpu_pkg::reg_addr_t'($urandom_range(0, 31));
			prog_rs2[i] = ($urandom_range(0, 1) == 1) ? prev_rd
				: cpu_pkg::reg_addr_t'($urandom_range(0, 31));
			off = int'($urandom_range(0, 7)) - 4; // small window so loads hit stores
			if (pick < 35) begin
				prog_op[i] = cpu_pkg::OP_REG;
				if (prog_f3[i] != 3'd0 && prog_f3[i] != 3'd5) prog_alt[i] = 1'b0;
				prog_imm[i]   = '0;
				prog_instr[i] = {1'b0, prog_alt[i], 5'b0, prog_rs2[i], prog_rs1[i],
					prog_f3[i], prog_rd[i], cpu_pkg::OP_REG};
			end else if (pick < 65) begin
				prog_op[i] = cpu_pkg::OP_IMM;
				if (prog_f3[i] != 3'd5) prog_alt[i] = 1'b0;
				if (prog_f3[i] == 3'd1 || prog_f3[i] == 3'd5)
					prog_imm[i] = {20'b0, 1'b0, prog_alt[i], 5'b0, 5'($urandom_range(0, 31))};
				else
					prog_imm[i] = {{20{imm12[11]}}, imm12};
				prog_instr[i] = {prog_imm[i][11:0], prog_rs1[i], prog_f3[i], prog_rd[i],
					cpu_pkg::OP_IMM};
			end else if (pick < 73) begin
				prog_op[i]    = cpu_pkg::OP_LUI;
				prog_alt[i]   = 1'b0;
				prog_imm[i]   = {20'($urandom), 12'b0};
				prog_instr[i] = {prog_imm[i][31:12], prog_rd[i], cpu_pkg::OP_LUI};
			end else if (pick < 86) begin
				prog_op[i]    = cpu_pkg::OP_LOAD;
				prog_alt[i]   = 1'b0;
				prog_rs1[i]   = 5'd1;
				prog_imm[i]   = cpu_pkg::word_t'(off * 4);
				prog_instr[i] = {prog_imm[i][11:0], 5'd1, cpu_pkg::MEM_WORD, prog_rd[i],
					cpu_pkg::OP_LOAD};
			end else begin
				prog_op[i]    = cpu_pkg::OP_STORE;
				prog_alt[i]   = 1'b0;
				prog_rd[i]    = '0;
				prog_rs1[i]   = 5'd1;
				prog_imm[i]   = cpu_pkg::word_t'(off * 4);
				prog_instr[i] = {prog_imm[i][11:5], prog_rs2[i], 5'd1, cpu_pkg::MEM_WORD,
					prog_imm[i][4:0], cpu_pkg::OP_STORE};
			end
			prev_rd = prog_rd[i];
		end
	endtask

	task automatic execute_reference(input int i);
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		cpu_pkg::word_t addr;
		cpu_pkg::word_t res;
		a    = ref_regs[prog_rs1[i]];
		b    = ref_regs[prog_rs2[i]];
		addr = a + prog_imm[i];
		res  = '0;
		case (prog_op[i])
			cpu_pkg::OP_REG: res = alu_ref(prog_f3[i], prog_alt[i], a, b);
			cpu_pkg::OP_IMM: res = alu_ref(prog_f3[i], prog_alt[i], a, prog_imm[i]);
			cpu_pkg::OP_LUI: res = prog_imm[i];
			cpu_pkg::OP_LOAD: begin
				res = ref_mem[addr[7:2]];
				if (stored[addr[7:2]]) load_hits++;
			end
			cpu_pkg::OP_STORE: begin
				ref_mem[addr[7:2]] = b;
				stored[addr[7:2]]  = 1'b1;
				exp_store.push_back(1'b1);
				exp_rd.push_back('0);
				exp_addr.push_back(addr);
				exp_data.push_back(b);
			end
			default: ;
		endcase
		if (prog_rd[i] != '0) begin // x0 targets retire silently
			ref_regs[prog_rd[i]] = res;
			exp_store.push_back(1'b0);
			exp_rd.push_back(prog_rd[i]);
			exp_addr.push_back('0);
			exp_data.push_back(res);
		end
	endtask

	task automatic retire_expected();
		exp_store.delete(0);
		exp_rd.delete(0);
		exp_addr.delete(0);
		exp_data.delete(0);
	endtask

	task automatic drive_inputs();
		rdy <= ($urandom_range(0, 99) < 85);
		if (idx < N_INSTR && $urandom_range(0, 99) < 80) begin
			instr_valid <= 1'b1;
			instr       <= prog_instr[idx];
		end else begin
			instr_valid <= 1'b0;
			instr       <= $urandom; // junk while invalid
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic accepted;
		void'($urandom(4717));
		rdy         <= 1'b1;
		instr_valid <= 1'b0;
		instr       <= '0;
		stall_cycles = 0;
		load_hits    = 0;
		idx          = 0;
		ex_rd        = '0;
		for (int i = 0; i < 64; i++) begin
			mem[i]     <= fill_word(i);
			ref_mem[i] = fill_word(i);
			stored[i]  = 1'b0;
		end
		for (int i = 0; i < cpu_pkg::REG_COUNT; i++) ref_regs[i] = '0;
		make_program();

		@(posedge clk);
		while (reset) @(posedge clk);
		check_bit("instr_ready", instr_ready, 1'b1);
		check_bit("wb_we", wb_we, 1'b0);
		check_bit("ma_we", ma_we, 1'b0);
		check_bit("ma_re", ma_re, 1'b0);
		drive_inputs();

		while (idx < N_INSTR) begin
			@(posedge clk);
			accepted = instr_valid && instr_ready && rdy;
			check_bit("instr_ready", instr_ready,
				rdy && !(instr_valid && causes_stall(idx, ex_rd)));
			if (instr_valid && rdy && !instr_ready) stall_cycles++;
			if (rdy) ex_rd = '0; // a bubble unless something is taken
			if (accepted) begin
				execute_reference(idx);
				ex_rd = prog_rd[idx];
				idx++;
			end
			drive_inputs();
		end

		rdy         <= 1'b1;
		instr_valid <= 1'b0;
		while (exp_data.size() != 0) @(posedge clk);
		repeat (4) @(posedge clk); // catch stray results after the last one

		if (stall_cycles == 0 || load_hits == 0)
			report_failure("the run saw no dependency stall or no load after a store");
		else begin
			$display("Regression passed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// monitor and memory model
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!reset) begin
			if (!rdy) begin // frozen pipe issues nothing
				check_bit("wb_we", wb_we, 1'b0);
				check_bit("ma_we", ma_we, 1'b0);
				check_bit("ma_re", ma_re, 1'b0);
			end
			if (ma_we || ma_re) // word access only
				check_mem_width("ma_width", ma_width, cpu_pkg::MEM_WORD);
			if (wb_we) begin
				if (exp_data.size() == 0 || exp_store[0])
					report_failure("register write-back with no register write pending");
				check_reg_addr("wb_waddr", wb_waddr, exp_rd[0]);
				check_word("wb_wdata", wb_wdata, exp_data[0]);
				retire_expected();
			end
			if (ma_we) begin
				if (exp_data.size() == 0 || !exp_store[0])
					report_failure("memory store with no store pending");
				check_word("ma_addr", ma_addr, exp_addr[0]);
				check_word("ma_wdata", ma_wdata, exp_data[0]);
				mem[ma_addr[7:2]] <= ma_wdata;
				retire_expected();
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
			report_failure("timeout: the pipeline did not finish the program in time");
	end

endmodule

`default_nettype wire
